// ==== common/crPkg.sv ====
`default_nettype none

package crPkg;

	localparam int CrIdWidth = 5;
	localparam int DataWidth = 64;

	localparam logic [CrIdWidth-1:0] CrPc   = 5'd0;
	localparam logic [CrIdWidth-1:0] CrLr   = 5'd1;
	localparam logic [CrIdWidth-1:0] CrSr   = 5'd2;
	localparam logic [CrIdWidth-1:0] CrVbr  = 5'd3;
	localparam logic [CrIdWidth-1:0] CrSpc  = 5'd4;
	localparam logic [CrIdWidth-1:0] CrSsp  = 5'd5;
	localparam logic [CrIdWidth-1:0] CrGbr  = 5'd6;
	localparam logic [CrIdWidth-1:0] CrTbr  = 5'd7;
	localparam logic [CrIdWidth-1:0] CrTea  = 5'd8;
	localparam logic [CrIdWidth-1:0] CrExsr = 5'd9;
	localparam logic [CrIdWidth-1:0] CrTtb  = 5'd10;
	localparam logic [CrIdWidth-1:0] CrMmcr = 5'd11;
	localparam logic [CrIdWidth-1:0] CrSttb = 5'd12;
	localparam logic [CrIdWidth-1:0] CrKrr  = 5'd13;
	localparam logic [CrIdWidth-1:0] CrZzr  = 5'd31;

	typedef enum logic [2:0] {
		OpRead      = 3'd0,
		OpWrite     = 3'd1,
		OpSetBits   = 3'd2,
		OpClearBits = 3'd3,
		OpAdd       = 3'd4
	} crOp;

	typedef struct packed {
		crOp                  op;
		logic [CrIdWidth-1:0] id;
		logic [DataWidth-1:0] data;
	} crCommand;

	function automatic logic crIsWide(input logic [CrIdWidth-1:0] id);
		return (id == CrSr) || (id == CrExsr) || (id == CrMmcr) || (id == CrKrr);
	endfunction

	function automatic logic crIsMmu(input logic [CrIdWidth-1:0] id);
		return (id >= CrTtb) && (id <= CrKrr);
	endfunction

	// Storage exists for PC..EXSR, plus the MMU bank when enabled
	function automatic logic crExists(input logic [CrIdWidth-1:0] id, input bit enableMmu);
		return (id <= CrExsr) || (enableMmu && crIsMmu(id));
	endfunction

	function automatic logic crIsWritable(input logic [CrIdWidth-1:0] id, input bit enableMmu);
		return crExists(id, enableMmu) && (id != CrPc);
	endfunction

	function automatic logic [DataWidth-1:0] crMask(
		input logic [CrIdWidth-1:0] id,
		input logic [DataWidth-1:0] value
	);
		return crIsWide(id) ? value : {32'b0, value[31:0]};
	endfunction

endpackage

`default_nettype wire

// ==== common/crStageIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface crStageIf;

	logic                        valid;
	crPkg::crCommand             cmd;
	logic [crPkg::DataWidth-1:0] oldValue;	// Register value read in RF
	logic [crPkg::DataWidth-1:0] newValue;	// Result of the op, unmasked

	modport exec (
		output valid,
		output cmd,
		output oldValue,
		output newValue
	);

	modport file (
		input valid,
		input cmd,
		input newValue
	);

	modport ctrl (
		input valid
	);

endinterface

`default_nettype wire

// ==== crFile/crFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module crFile #(
	parameter bit          EnableMmu   = 1'b1,
	parameter logic [31:0] ResetVector = 32'h1000
) (
	input  wire logic                        clock,
	input  wire logic                        reset,
	input  wire logic                        hold,
	input  wire logic [crPkg::CrIdWidth-1:0] readId,
	output logic      [crPkg::DataWidth-1:0] readValue,
	input  wire logic [31:0]                 nextPc,
	output logic      [31:0]                 pc,
	crStageIf.file                           ex1,
	crStageIf.file                           ex2
);

	logic [31:0] pcReg;
	logic [31:0] lrReg;
	logic [63:0] srReg;
	logic [31:0] vbrReg;
	logic [31:0] spcReg;
	logic [31:0] sspReg;
	logic [31:0] gbrReg;
	logic [31:0] tbrReg;
	logic [31:0] teaReg;
	logic [63:0] exsrReg;
	logic [31:0] ttbReg;
	logic [63:0] mmcrReg;
	logic [31:0] sttbReg;
	logic [63:0] krrReg;

	logic [crPkg::DataWidth-1:0] storedValue;
	logic                        ex1Writes;
	logic                        ex2Writes;
	logic                        writeEnable;

	assign pc = pcReg;

	assign ex1Writes = ex1.valid && (ex1.cmd.op != crPkg::OpRead)
		&& crPkg::crIsWritable(ex1.cmd.id, EnableMmu);
	assign ex2Writes = ex2.valid && (ex2.cmd.op != crPkg::OpRead)
		&& crPkg::crIsWritable(ex2.cmd.id, EnableMmu);
	assign writeEnable = ex2Writes && !hold;	// EX2 retires this cycle

	always_comb
	begin
		case (readId)
			crPkg::CrPc:   storedValue = {32'b0, pcReg};
			crPkg::CrLr:   storedValue = {32'b0, lrReg};
			crPkg::CrSr:   storedValue = srReg;
			crPkg::CrVbr:  storedValue = {32'b0, vbrReg};
			crPkg::CrSpc:  storedValue = {32'b0, spcReg};
			crPkg::CrSsp:  storedValue = {32'b0, sspReg};
			crPkg::CrGbr:  storedValue = {32'b0, gbrReg};
			crPkg::CrTbr:  storedValue = {32'b0, tbrReg};
			crPkg::CrTea:  storedValue = {32'b0, teaReg};
			crPkg::CrExsr: storedValue = exsrReg;
			crPkg::CrTtb:  storedValue = EnableMmu ? {32'b0, ttbReg} : '0;
			crPkg::CrMmcr: storedValue = EnableMmu ? mmcrReg : '0;
			crPkg::CrSttb: storedValue = EnableMmu ? {32'b0, sttbReg} : '0;
			crPkg::CrKrr:  storedValue = EnableMmu ? krrReg : '0;
			default:       storedValue = '0;	// ZZR and unknown ids
		endcase
	end

	// EX1 is younger than EX2, so it wins
	always_comb
	begin
		readValue = storedValue;
		if (ex2Writes && (ex2.cmd.id == readId))
			readValue = crPkg::crMask(readId, ex2.newValue);
		if (ex1Writes && (ex1.cmd.id == readId))
			readValue = crPkg::crMask(readId, ex1.newValue);
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			pcReg   <= ResetVector;
			lrReg   <= '0;
			srReg   <= '0;
			vbrReg  <= '0;
			spcReg  <= '0;
			sspReg  <= '0;
			gbrReg  <= '0;
			tbrReg  <= '0;
			teaReg  <= '0;
			exsrReg <= '0;
			ttbReg  <= '0;
			mmcrReg <= '0;
			sttbReg <= '0;
			krrReg  <= '0;
		end
		else
		begin
			if (!hold)
				pcReg <= nextPc;
			if (writeEnable)
			begin
				case (ex2.cmd.id)
					crPkg::CrLr:   lrReg   <= ex2.newValue[31:0];
					crPkg::CrSr:   srReg   <= ex2.newValue;
					crPkg::CrVbr:  vbrReg  <= ex2.newValue[31:0];
					crPkg::CrSpc:  spcReg  <= ex2.newValue[31:0];
					crPkg::CrSsp:  sspReg  <= ex2.newValue[31:0];
					crPkg::CrGbr:  gbrReg  <= ex2.newValue[31:0];
					crPkg::CrTbr:  tbrReg  <= ex2.newValue[31:0];
					crPkg::CrTea:  teaReg  <= ex2.newValue[31:0];
					crPkg::CrExsr: exsrReg <= ex2.newValue;
					crPkg::CrTtb:  ttbReg  <= ex2.newValue[31:0];
					crPkg::CrMmcr: mmcrReg <= ex2.newValue;
					crPkg::CrSttb: sttbReg <= ex2.newValue[31:0];
					crPkg::CrKrr:  krrReg  <= ex2.newValue;
					default:       ;
				endcase
			end
		end
	end

	// PC only moves with the pipeline, never through the write port
	pcWriteBlocked: assert property (
		@(posedge clock) disable iff (reset)
		(ex2.valid && (ex2.cmd.op != crPkg::OpRead) && (ex2.cmd.id == crPkg::CrPc) && !hold)
			|=> (pcReg == $past(nextPc))
	) else $error("EX2 write to PC accepted");

endmodule

`default_nettype wire

// ==== dv/crUnitChecker.sv ====
`timescale 1ns/1ps
`default_nettype none

module crUnitChecker #(
	parameter int          CmdDepth    = 4,
	parameter int          OutCredits  = 2,
	parameter bit          EnableMmu   = 1'b1,
	parameter logic [31:0] ResetVector = 32'h1000
) (
	input  wire logic                        clock,
	input  wire logic                        reset,
	input  wire logic                        cmdValid,
	input  wire crPkg::crOp                  cmdOp,
	input  wire logic [crPkg::CrIdWidth-1:0] cmdId,
	input  wire logic [crPkg::DataWidth-1:0] cmdData,
	input  wire logic                        cmdCreditReturn,
	input  wire logic                        resultValid,
	input  wire logic [crPkg::DataWidth-1:0] resultValue,
	input  wire logic [crPkg::CrIdWidth-1:0] resultId,
	input  wire logic                        resultCreditReturn,
	input  int                               testIndex,
	input  wire logic                        testEnd,
	output int                               pending,
	output int                               errorCount,
	output int                               testsPassed,
	output int                               testsFailed
);

	logic [63:0] model [32];
	logic [63:0] expectedValues [$];
	logic [4:0]  expectedIds [$];
	int          commandIndex;	// Commands seen since reset, sets PC
	int          senderCredits;
	int          dutCredits;
	int          testChecks;
	int          testErrors;

	function automatic string testName(input int index);
		case (index)
			0:       return "writeReadBackToBack";
			1:       return "readModifyWrite";
			2:       return "specialIds";
			3:       return "pcReads";
			4:       return "backPressure";
			default: return "unnamed";
		endcase
	endfunction

	// Applies one command to the model, returns the old value the DUT must report
	function automatic logic [63:0] referenceOldValue(
		input crPkg::crOp  op,
		input logic [4:0]  id,
		input logic [63:0] data
	);
		logic        present;
		logic [63:0] oldValue;
		logic [63:0] newValue;
		present = (id <= crPkg::CrExsr) || (EnableMmu && id >= crPkg::CrTtb && id <= crPkg::CrKrr);
		if (id == crPkg::CrPc)
			oldValue = {32'b0, ResetVector + 32'(4 * commandIndex)};
		else if (present)
			oldValue = model[id];
		else
			oldValue = '0;
		case (op)
			crPkg::OpWrite:     newValue = data;
			crPkg::OpSetBits:   newValue = oldValue | data;
			crPkg::OpClearBits: newValue = oldValue & ~data;
			crPkg::OpAdd:       newValue = oldValue + data;
			default:            newValue = oldValue;
		endcase
		if (op != crPkg::OpRead && present && id != crPkg::CrPc)
			model[id] = crPkg::crIsWide(id) ? newValue : {32'b0, newValue[31:0]};
		commandIndex++;
		return oldValue;
	endfunction

	task automatic reportFailure(input string what);
		$display("%s in test %s", what, testName(testIndex));
		testErrors++;
		errorCount++;
	endtask

	always @(posedge clock)
	begin : monitor
		logic [63:0] expValue;
		logic [4:0]  expId;
		if (reset)
		begin
			for (int i = 0; i < 32; i++)
				model[i] = '0;
			expectedValues.delete();
			expectedIds.delete();
			commandIndex  = 0;
			senderCredits = CmdDepth;
			dutCredits    = OutCredits;
			pending       = 0;
			errorCount    = 0;
			testsPassed   = 0;
			testsFailed   = 0;
			testChecks    = 0;
			testErrors    = 0;
		end
		else
		begin
			if (resultValid)
			begin
				if (expectedValues.size() == 0)
					reportFailure("a result arrived with no command outstanding");
				else
				begin
					expValue = expectedValues.pop_front();
					expId    = expectedIds.pop_front();
					testChecks++;
					if (resultValue !== expValue || resultId !== expId)
					begin
						$display("** Error test %s: expected id %0d value %h, actual id %0d value %h",
							testName(testIndex), expId, expValue, resultId, resultValue);
						testErrors++;
						errorCount++;
					end
				end
			end
			if (cmdValid)
			begin
				expectedValues.push_back(referenceOldValue(cmdOp, cmdId, cmdData));
				expectedIds.push_back(cmdId);
			end
			pending = expectedValues.size();

			senderCredits = senderCredits - int'(cmdValid) + int'(cmdCreditReturn);
			if (senderCredits > CmdDepth)
				reportFailure("a command credit was returned with no command queued");
			if (resultValid && dutCredits == 0)
				reportFailure("a result was delivered with no result credit outstanding");
			dutCredits = dutCredits - int'(resultValid) + int'(resultCreditReturn);

			if (testEnd)
			begin
				if (pending != 0)
					reportFailure($sformatf("%0d results were missing", pending));
				if (senderCredits != CmdDepth)
					reportFailure("command credits were not all returned");
				if (testErrors == 0)
				begin
					testsPassed++;
					$display("test %s passed, %0d results checked", testName(testIndex), testChecks);
				end
				else
				begin
					testsFailed++;
					$display("test %s FAILED with %0d errors", testName(testIndex), testErrors);
				end
				testChecks = 0;
				testErrors = 0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== dv/crUnitTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module crUnitTb;

	localparam int          CmdDepth      = 4;
	localparam int          OutCredits    = 2;
	localparam bit          EnableMmu     = 1'b1;
	localparam logic [31:0] ResetVector   = 32'h1000;
	localparam int          RmwCount      = 30;
	localparam int          PcCount       = 6;
	localparam int          PressureCount = 16;
	localparam int          TotalCommands = 39 + RmwCount + 10 + PcCount + PressureCount;
	localparam int          TimeoutCycles = TotalCommands * 8 + 200;

	logic        clock;
	logic        reset;
	logic        cmdValid;
	crPkg::crOp  cmdOp;
	logic [4:0]  cmdId;
	logic [63:0] cmdData;
	logic        cmdCreditReturn;
	logic        resultValid;
	logic [63:0] resultValue;
	logic [4:0]  resultId;
	logic        resultCreditReturn;

	int          testIndex;
	logic        testEnd;
	int          pending;
	int          errorCount;
	int          testsPassed;
	int          testsFailed;
	int          cmdCredits;
	logic        withholdCredits;
	logic [31:0] lcgState = 32'd68;
	int          dueCycles [$];	// Cycle at which each owed result credit goes back
	int          cycleCount;
	logic [63:0] data;
	logic [4:0]  specialIds [5] = '{crPkg::CrZzr, 5'd14, 5'd20, 5'd30, crPkg::CrPc};
	logic [4:0]  rmwIds [3] = '{crPkg::CrLr, crPkg::CrSr, crPkg::CrExsr};

	crUnitTop #(
		.CmdDepth    (CmdDepth),
		.OutCredits  (OutCredits),
		.EnableMmu   (EnableMmu),
		.ResetVector (ResetVector)
	) crUnitTop_inst (
		.clock              (clock),
		.reset              (reset),
		.cmdValid           (cmdValid),
		.cmdOp              (cmdOp),
		.cmdId              (cmdId),
		.cmdData            (cmdData),
		.cmdCreditReturn    (cmdCreditReturn),
		.resultValid        (resultValid),
		.resultValue        (resultValue),
		.resultId           (resultId),
		.resultCreditReturn (resultCreditReturn)
	);

	crUnitChecker #(
		.CmdDepth    (CmdDepth),
		.OutCredits  (OutCredits),
		.EnableMmu   (EnableMmu),
		.ResetVector (ResetVector)
	) crUnitChecker_inst (
		.clock              (clock),
		.reset              (reset),
		.cmdValid           (cmdValid),
		.cmdOp              (cmdOp),
		.cmdId              (cmdId),
		.cmdData            (cmdData),
		.cmdCreditReturn    (cmdCreditReturn),
		.resultValid        (resultValid),
		.resultValue        (resultValue),
		.resultId           (resultId),
		.resultCreditReturn (resultCreditReturn),
		.testIndex          (testIndex),
		.testEnd            (testEnd),
		.pending            (pending),
		.errorCount         (errorCount),
		.testsPassed        (testsPassed),
		.testsFailed        (testsFailed)
	);

	function automatic logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState;
	endfunction

	function automatic int randomBelow(input int limit);
		return int'((nextRandom() >> 16) % limit);	// Upper bits, low ones cycle fast
	endfunction

	function automatic logic [63:0] randomData();
		logic [31:0] upper;
		upper = nextRandom();
		return {upper, nextRandom()};
	endfunction

	function automatic crPkg::crOp pickOp(input int sel);
		case (sel)
			0:       return crPkg::OpRead;
			1:       return crPkg::OpWrite;
			2:       return crPkg::OpSetBits;
			3:       return crPkg::OpClearBits;
			default: return crPkg::OpAdd;
		endcase
	endfunction

	initial
	begin
		clock = 1'b0;
		forever
			#4 clock = ~clock;
	end

	always @(posedge clock)
	begin
		if (reset)
			cmdCredits <= CmdDepth;
		else
			cmdCredits <= cmdCredits - int'(cmdValid) + int'(cmdCreditReturn);
	end

	// Consumer gives each result credit back 0 to 3 cycles later
	always @(posedge clock)
	begin
		cycleCount++;
		if (!reset && resultValid)
			dueCycles.push_back(cycleCount + randomBelow(4));
		#1;
		if (!reset && !withholdCredits && dueCycles.size() != 0 && dueCycles[0] <= cycleCount)
		begin
			void'(dueCycles.pop_front());
			resultCreditReturn = 1'b1;
		end
		else
			resultCreditReturn = 1'b0;
	end

	task automatic sendCommand(input crPkg::crOp op, input logic [4:0] id, input logic [63:0] value);
		@(posedge clock);
		#1;
		cmdValid = 1'b0;
		while (cmdCredits == 0)
		begin
			@(posedge clock);
			#1;
		end
		cmdValid = 1'b1;
		cmdOp    = op;
		cmdId    = id;
		cmdData  = value;
	endtask

	task automatic finishTest();
		@(posedge clock);
		#1;
		cmdValid = 1'b0;
		while (pending != 0)
		begin
			@(posedge clock);
			#1;
		end
		testEnd = 1'b1;
		@(posedge clock);
		#1;
		testEnd = 1'b0;
		testIndex++;
	endtask

	initial
	begin
		reset              = 1'b1;
		cmdValid           = 1'b0;
		cmdOp              = crPkg::OpRead;
		cmdId              = '0;
		cmdData            = '0;
		resultCreditReturn = 1'b0;
		withholdCredits    = 1'b0;
		testIndex          = 0;
		testEnd            = 1'b0;
		cycleCount         = 0;
		repeat (2) @(posedge clock);
		#1;
		reset = 1'b0;

		for (int id = 1; id <= 13; id++)
		begin
			data = randomData();
			sendCommand(crPkg::OpWrite, 5'(id), data);
			sendCommand(crPkg::OpRead, 5'(id), '0);	// Forwarded from EX1
			sendCommand(crPkg::OpRead, 5'(id), '0);	// Forwarded from EX2
		end
		finishTest();

		for (int i = 0; i < RmwCount; i++)
		begin
			data = randomData();
			sendCommand(pickOp(2 + randomBelow(3)), rmwIds[randomBelow(3)], data);
		end
		finishTest();

		for (int i = 0; i < 5; i++)
		begin
			data = randomData();
			sendCommand(crPkg::OpWrite, specialIds[i], data);
			sendCommand(crPkg::OpRead, specialIds[i], '0);
		end
		finishTest();

		for (int i = 0; i < PcCount; i++)
			sendCommand(crPkg::OpRead, crPkg::CrPc, '0);
		finishTest();

		withholdCredits = 1'b1;
		fork
			for (int i = 0; i < PressureCount; i++)
			begin
				data = randomData();
				sendCommand(pickOp(randomBelow(5)), 5'(randomBelow(14)), data);
			end
			begin
				repeat (30) @(posedge clock);
				withholdCredits = 1'b0;
			end
		join
		finishTest();

		$display("Tests passed: %0d, failed: %0d, errors: %0d", testsPassed, testsFailed, errorCount);
		if (testsFailed == 0 && errorCount == 0 && testsPassed == 5)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	initial
	begin
		repeat (TimeoutCycles) @(posedge clock);
		$display("Results stopped arriving before all tests finished");
		$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== source/crCmdQueue.sv ====
`timescale 1ns/1ps
`default_nettype none

module crCmdQueue #(
	parameter int Depth = 4
) (
	input  wire logic            clock,
	input  wire logic            reset,
	input  wire logic            pushValid,
	input  wire crPkg::crCommand pushCmd,
	input  wire logic            pop,
	output logic                 headValid,
	output crPkg::crCommand      headCmd
);

	localparam int PtrWidth   = (Depth > 1) ? $clog2(Depth) : 1;
	localparam int CountWidth = $clog2(Depth + 1);

	crPkg::crCommand       entries [Depth];
	logic [PtrWidth-1:0]   writePtr;
	logic [PtrWidth-1:0]   readPtr;
	logic [CountWidth-1:0] count;
	logic                  doPop;

	function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] ptr);
		return (ptr == PtrWidth'(Depth - 1)) ? '0 : ptr + 1'b1;	// Wrap for any depth
	endfunction

	assign headValid = (count != '0);
	assign headCmd   = entries[readPtr];
	assign doPop     = pop && headValid;

	always_ff @(posedge clock)
	begin
		if (pushValid)
			entries[writePtr] <= pushCmd;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			writePtr <= '0;
			readPtr  <= '0;
			count    <= '0;
		end
		else
		begin
			if (pushValid)
				writePtr <= nextPtr(writePtr);
			if (doPop)
				readPtr <= nextPtr(readPtr);
			count <= count + CountWidth'(pushValid) - CountWidth'(doPop);
		end
	end

	// Sender pushed without holding a credit
	noPushWhenFull: assert property (
		@(posedge clock) disable iff (reset)
		pushValid |-> (count != CountWidth'(Depth))
	) else $error("command pushed into a full queue, sender overran its credits");

endmodule

`default_nettype wire

// ==== source/crExecute.sv ====
`timescale 1ns/1ps
`default_nettype none

module crExecute (
	input  wire logic                        clock,
	input  wire logic                        reset,
	input  wire logic                        hold,
	input  wire logic                        pop,
	input  wire crPkg::crCommand             headCmd,
	input  wire logic [crPkg::DataWidth-1:0] readValue,
	crStageIf.exec                           ex1,
	crStageIf.exec                           ex2,
	output logic      [crPkg::DataWidth-1:0] resultValue,
	output logic      [crPkg::CrIdWidth-1:0] resultId
);

	function automatic logic [crPkg::DataWidth-1:0] applyOp(
		input crPkg::crOp                  op,
		input logic [crPkg::DataWidth-1:0] oldValue,
		input logic [crPkg::DataWidth-1:0] operand
	);
		case (op)
			crPkg::OpWrite:     return operand;
			crPkg::OpSetBits:   return oldValue | operand;
			crPkg::OpClearBits: return oldValue & ~operand;
			crPkg::OpAdd:       return oldValue + operand;	// Wraps mod 2^64
			default:            return oldValue;
		endcase
	endfunction

	assign ex1.newValue = applyOp(ex1.cmd.op, ex1.oldValue, ex1.cmd.data);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			ex1.valid <= 1'b0;
			ex2.valid <= 1'b0;
		end
		else if (!hold)
		begin
			ex1.valid <= pop;	// Bubble when queue is empty
			ex2.valid <= ex1.valid;
		end
	end

	always_ff @(posedge clock)
	begin
		if (!hold)
		begin
			if (pop)
			begin
				ex1.cmd      <= headCmd;
				ex1.oldValue <= readValue;
			end
			ex2.cmd      <= ex1.cmd;
			ex2.oldValue <= ex1.oldValue;
			ex2.newValue <= ex1.newValue;
		end
	end

	assign resultValue = ex2.oldValue;
	assign resultId    = ex2.cmd.id;

endmodule

`default_nettype wire

// ==== source/crPipeControl.sv ====
`timescale 1ns/1ps
`default_nettype none

module crPipeControl #(
	parameter int OutCredits = 2
) (
	input  wire logic        clock,
	input  wire logic        reset,
	input  wire logic        headValid,
	crStageIf.ctrl           ex1,
	crStageIf.ctrl           ex2,
	input  wire logic        resultCreditReturn,
	input  wire logic [31:0] pc,
	output logic             hold,
	output logic             pop,
	output logic             cmdCreditReturn,
	output logic             resultValid,
	output logic      [31:0] nextPc
);

	localparam int CountWidth = $clog2(OutCredits + 1);

	logic [CountWidth-1:0] creditCount;

	// Freeze everything when the result has nowhere to go
	assign hold = ex2.valid && (creditCount == '0);

	assign resultValid     = ex2.valid && !hold;
	assign pop             = headValid && !hold;
	assign cmdCreditReturn = pop;	// Slot frees as head enters EX1

	assign nextPc = pop ? pc + 32'd4 : pc;

	always_ff @(posedge clock)
	begin
		if (reset)
			creditCount <= CountWidth'(OutCredits);
		else
			creditCount <= creditCount - CountWidth'(resultValid)
				+ CountWidth'(resultCreditReturn);
	end

	creditBound: assert property (
		@(posedge clock) disable iff (reset)
		!(resultCreditReturn && !resultValid
			&& (creditCount == CountWidth'(OutCredits)))
	) else $error("result credit returned beyond the %0d granted", OutCredits);

	// Popped command must show up in EX1 on the next cycle
	popFillsEx1: assert property (
		@(posedge clock) disable iff (reset)
		pop |=> ex1.valid
	) else $error("popped command did not reach EX1");

endmodule

`default_nettype wire

// ==== source/crUnitTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module crUnitTop #(
	parameter int          CmdDepth    = 4,
	parameter int          OutCredits  = 2,
	parameter bit          EnableMmu   = 1'b1,
	parameter logic [31:0] ResetVector = 32'h1000
) (
	input  wire logic                        clock,
	input  wire logic                        reset,
	input  wire logic                        cmdValid,
	input  wire crPkg::crOp                  cmdOp,
	input  wire logic [crPkg::CrIdWidth-1:0] cmdId,
	input  wire logic [crPkg::DataWidth-1:0] cmdData,
	output logic                             cmdCreditReturn,
	output logic                             resultValid,
	output logic      [crPkg::DataWidth-1:0] resultValue,
	output logic      [crPkg::CrIdWidth-1:0] resultId,
	input  wire logic                        resultCreditReturn
);

	crPkg::crCommand             pushCmd;
	crPkg::crCommand             headCmd;
	logic                        headValid;
	logic                        hold;
	logic                        pop;
	logic [crPkg::DataWidth-1:0] readValue;
	logic [31:0]                 pc;
	logic [31:0]                 nextPc;

	crStageIf ex1Stage ();
	crStageIf ex2Stage ();

	assign pushCmd = '{op: cmdOp, id: cmdId, data: cmdData};

	crCmdQueue #(
		.Depth (CmdDepth)
	) crCmdQueue_inst (
		.clock     (clock),
		.reset     (reset),
		.pushValid (cmdValid),
		.pushCmd   (pushCmd),
		.pop       (pop),
		.headValid (headValid),
		.headCmd   (headCmd)
	);

	crPipeControl #(
		.OutCredits (OutCredits)
	) crPipeControl_inst (
		.clock              (clock),
		.reset              (reset),
		.headValid          (headValid),
		.ex1                (ex1Stage),
		.ex2                (ex2Stage),
		.resultCreditReturn (resultCreditReturn),
		.pc                 (pc),
		.hold               (hold),
		.pop                (pop),
		.cmdCreditReturn    (cmdCreditReturn),
		.resultValid        (resultValid),
		.nextPc             (nextPc)
	);

	crExecute crExecute_inst (
		.clock       (clock),
		.reset       (reset),
		.hold        (hold),
		.pop         (pop),
		.headCmd     (headCmd),
		.readValue   (readValue),
		.ex1         (ex1Stage),
		.ex2         (ex2Stage),
		.resultValue (resultValue),
		.resultId    (resultId)
	);

	crFile #(
		.EnableMmu   (EnableMmu),
		.ResetVector (ResetVector)
	) crFile_inst (
		.clock     (clock),
		.reset     (reset),
		.hold      (hold),
		.readId    (headCmd.id),	// RF reads for the queue head
		.readValue (readValue),
		.nextPc    (nextPc),
		.pc        (pc),
		.ex1       (ex1Stage),
		.ex2       (ex2Stage)
	);

endmodule

`default_nettype wire

// ==== tb.f ====
common/crPkg.sv
common/crStageIf.sv
crFile/crFile.sv
source/crCmdQueue.sv
source/crPipeControl.sv
source/crExecute.sv
source/crUnitTop.sv
dv/crUnitChecker.sv
dv/crUnitTb.sv
